/* pg_settings.svh */
`ifndef PG_SETTINGS_SVH
`define PG_SETTINGS_SVH

// screen size in pixels
`define PG_WIDTH 16
`define PG_HEIGHT 8

`define PG_LANES 4          // shading lanes in parallel
`define PG_FIFO_DEPTH 8     // packer FIFO entries, also the scanner credit count
`define PG_SHIFT 2          // falloff shift applied to d2

// AXI-Lite register file
`define PG_AXI_ADDR_WIDTH 8
`define PG_REG_FILE_SIZE 8

`endif

/* pg_pkg.sv */
`default_nettype none

package pg_pkg;

    typedef logic signed [15:0] coord_t;   // screen coordinate, also cx/cy/k
    typedef logic [7:0]         shade_t;   // one channel or falloff value
    typedef logic [23:0]        rgb_t;     // {red, green, blue}
    typedef logic [31:0]        dist_t;    // squared distance

    // AXI-Lite write side, address and data may come in either order
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_AWAIT_DATA,
        WR_AWAIT_ADDR,
        WR_WRITE,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_RESP
    } rd_state_e;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_e;

endpackage

`default_nettype wire

/* pg_if.sv */
`timescale 1ns/1ns
`default_nettype none

// scanner to lane, no back-pressure
interface pixel_req_if;
    logic           valid;  // one-cycle strobe
    pg_pkg::coord_t x;
    pg_pkg::coord_t y;
    logic           sof;    // first pixel of the frame
    logic           eol;    // last pixel of the line

    modport src (output valid, x, y, sof, eol);
    modport sink (input valid, x, y, sof, eol);
endinterface

// lane to packer
interface shade_if;
    logic         valid;    // one-cycle strobe
    pg_pkg::rgb_t rgb;
    logic         sof;
    logic         eol;

    modport src (output valid, rgb, sof, eol);
    modport sink (input valid, rgb, sof, eol);
endinterface

`default_nettype wire

/* axi_lite_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module axi_lite_regs (
    input  logic                          out_stream_aclk,
    input  logic                          axi_resetn,
    input  logic [`PG_AXI_ADDR_WIDTH-1:0] s_axi_lite_awaddr,
    input  logic                          s_axi_lite_awvalid,
    output logic                          s_axi_lite_awready,
    input  logic [31:0]                   s_axi_lite_wdata,
    input  logic                          s_axi_lite_wvalid,
    output logic                          s_axi_lite_wready,
    output logic [1:0]                    s_axi_lite_bresp,
    output logic                          s_axi_lite_bvalid,
    input  logic                          s_axi_lite_bready,
    input  logic [`PG_AXI_ADDR_WIDTH-1:0] s_axi_lite_araddr,
    input  logic                          s_axi_lite_arvalid,
    output logic                          s_axi_lite_arready,
    output logic [31:0]                   s_axi_lite_rdata,
    output logic [1:0]                    s_axi_lite_rresp,
    output logic                          s_axi_lite_rvalid,
    input  logic                          s_axi_lite_rready,
    output logic                          run,
    output pg_pkg::coord_t                cx,
    output pg_pkg::coord_t                cy,
    output pg_pkg::coord_t                k,
    output pg_pkg::rgb_t                  tint
);
    localparam int RA = $clog2(`PG_REG_FILE_SIZE);
    localparam int WA = `PG_AXI_ADDR_WIDTH - 2;   // word address bits
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0]       regfile [`PG_REG_FILE_SIZE];
    logic [WA-1:0]     wr_addr;
    logic [WA-1:0]     rd_addr;
    logic [31:0]       wr_data;
    pg_pkg::wr_state_e wr_state;
    pg_pkg::rd_state_e rd_state;
    logic              aw_take;
    logic              w_take;
    logic              wr_ok;
    logic              rd_ok;

    assign s_axi_lite_awready = (wr_state == pg_pkg::WR_IDLE) ||
                                (wr_state == pg_pkg::WR_AWAIT_ADDR);
    assign s_axi_lite_wready  = (wr_state == pg_pkg::WR_IDLE) ||
                                (wr_state == pg_pkg::WR_AWAIT_DATA);
    assign aw_take = s_axi_lite_awvalid && s_axi_lite_awready;
    assign w_take  = s_axi_lite_wvalid && s_axi_lite_wready;

    assign wr_ok = wr_addr < WA'(`PG_REG_FILE_SIZE);
    assign rd_ok = rd_addr < WA'(`PG_REG_FILE_SIZE);

    assign s_axi_lite_bvalid = (wr_state == pg_pkg::WR_RESP);
    assign s_axi_lite_bresp  = wr_ok ? RESP_OKAY : RESP_SLVERR;
    assign s_axi_lite_arready = (rd_state == pg_pkg::RD_IDLE);
    assign s_axi_lite_rvalid  = (rd_state == pg_pkg::RD_RESP);
    assign s_axi_lite_rresp   = rd_ok ? RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge out_stream_aclk) begin
        if (aw_take)
            wr_addr <= s_axi_lite_awaddr[`PG_AXI_ADDR_WIDTH-1:2];
        if (w_take)
            wr_data <= s_axi_lite_wdata;
        if (s_axi_lite_arvalid && s_axi_lite_arready)
            rd_addr <= s_axi_lite_araddr[`PG_AXI_ADDR_WIDTH-1:2];
        if (rd_state == pg_pkg::RD_FETCH)
            s_axi_lite_rdata <= rd_ok ? regfile[rd_addr[RA-1:0]] : '0;
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_state <= pg_pkg::WR_IDLE;
            for (int i = 0; i < `PG_REG_FILE_SIZE; i++)
                regfile[i] <= '0;
        end else begin
            case (wr_state)
                pg_pkg::WR_IDLE: begin
                    case ({aw_take, w_take})
                        2'b11:   wr_state <= pg_pkg::WR_WRITE;
                        2'b10:   wr_state <= pg_pkg::WR_AWAIT_DATA;
                        2'b01:   wr_state <= pg_pkg::WR_AWAIT_ADDR;
                        default: wr_state <= pg_pkg::WR_IDLE;
                    endcase
                end
                pg_pkg::WR_AWAIT_DATA: if (w_take) wr_state <= pg_pkg::WR_WRITE;
                pg_pkg::WR_AWAIT_ADDR: if (aw_take) wr_state <= pg_pkg::WR_WRITE;
                pg_pkg::WR_WRITE: begin
                    if (wr_ok)
                        regfile[wr_addr[RA-1:0]] <= wr_data;  // out of range is dropped
                    wr_state <= pg_pkg::WR_RESP;
                end
                pg_pkg::WR_RESP: if (s_axi_lite_bready) wr_state <= pg_pkg::WR_IDLE;
                default: wr_state <= pg_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_state <= pg_pkg::RD_IDLE;
        end else begin
            case (rd_state)
                pg_pkg::RD_IDLE:  if (s_axi_lite_arvalid) rd_state <= pg_pkg::RD_FETCH;
                pg_pkg::RD_FETCH: rd_state <= pg_pkg::RD_RESP;
                pg_pkg::RD_RESP:  if (s_axi_lite_rready) rd_state <= pg_pkg::RD_IDLE;
                default:          rd_state <= pg_pkg::RD_IDLE;
            endcase
        end
    end

    // decoded fields
    assign run  = regfile[0][0];
    assign cx   = regfile[1][15:0];
    assign cy   = regfile[2][15:0];
    assign k    = regfile[3][15:0];
    assign tint = regfile[4][23:0];

    // response payload must not move while the master stalls
    a_bvalid_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_bvalid && !s_axi_lite_bready |=>
            s_axi_lite_bvalid && $stable(s_axi_lite_bresp));
    a_rvalid_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_rvalid && !s_axi_lite_rready |=>
            s_axi_lite_rvalid && $stable(s_axi_lite_rdata) && $stable(s_axi_lite_rresp));

endmodule

`default_nettype wire

/* pixel_scanner.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module pixel_scanner (
    input logic      out_stream_aclk,
    input logic      axi_resetn,
    input logic      run,
    input logic      slot_free,
    pixel_req_if.src req [`PG_LANES]
);
    localparam int LW = (`PG_LANES > 1) ? $clog2(`PG_LANES) : 1;
    localparam int CW = $clog2(`PG_FIFO_DEPTH + 1);

    pg_pkg::scan_state_e state;
    pg_pkg::coord_t      x;
    pg_pkg::coord_t      y;
    logic [LW-1:0]       lane;      // round-robin pointer
    logic [CW-1:0]       credits;   // free FIFO slots not yet claimed
    logic                issue;
    logic                last_x;
    logic                last_y;

    assign issue  = (state == pg_pkg::SCAN_RUN) && (credits != '0);
    assign last_x = (x == pg_pkg::coord_t'(`PG_WIDTH - 1));
    assign last_y = (y == pg_pkg::coord_t'(`PG_HEIGHT - 1));

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            state <= pg_pkg::SCAN_IDLE;
            x     <= '0;
            y     <= '0;
            lane  <= '0;
        end else begin
            case (state)
                pg_pkg::SCAN_IDLE: begin
                    lane <= '0;
                    if (run)            // run only matters at frame start
                        state <= pg_pkg::SCAN_RUN;
                end
                pg_pkg::SCAN_RUN: begin
                    if (issue) begin
                        lane <= (lane == LW'(`PG_LANES - 1)) ? '0 : lane + 1'b1;
                        if (last_x) begin
                            x <= '0;
                            if (last_y) begin
                                y     <= '0;
                                state <= pg_pkg::SCAN_IDLE;   // frame done
                            end else begin
                                y <= y + 1'b1;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: state <= pg_pkg::SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn)
            credits <= CW'(`PG_FIFO_DEPTH);
        else
            credits <= credits - CW'(issue) + CW'(slot_free);
    end

    for (genvar i = 0; i < `PG_LANES; i++) begin : g_req
        assign req[i].valid = issue && (lane == LW'(i));
        assign req[i].x     = x;
        assign req[i].y     = y;
        assign req[i].sof   = (x == '0) && (y == '0);
        assign req[i].eol   = last_x;
    end

    // a slot_free without a matching earlier issue would overshoot
    a_credit_max: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        credits <= CW'(`PG_FIFO_DEPTH));

endmodule

`default_nettype wire

/* shade_lane.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module shade_lane (
    input logic           out_stream_aclk,
    input logic           axi_resetn,
    input pg_pkg::coord_t cx,
    input pg_pkg::coord_t cy,
    input pg_pkg::coord_t k,
    input pg_pkg::rgb_t   tint,
    pixel_req_if.sink     req,
    shade_if.src          res
);
    pg_pkg::coord_t     dx;     // wraps at 16 bits
    pg_pkg::coord_t     dy;
    pg_pkg::dist_t      d2;
    logic               s1_valid;
    logic               s2_valid;
    logic               s1_sof;
    logic               s1_eol;
    logic               s2_sof;
    logic               s2_eol;
    logic signed [33:0] diff;
    pg_pkg::shade_t     v;
    logic [15:0]        prod_r;
    logic [15:0]        prod_g;
    logic [15:0]        prod_b;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            s1_valid  <= req.valid;
            s2_valid  <= s1_valid;
            res.valid <= s2_valid;
        end
    end

    // stage 3 clamp, k - (d2 >> shift) into 0..255
    assign diff = 34'(k) - $signed({2'b00, d2 >> `PG_SHIFT});

    always_comb begin
        if (diff < 0)
            v = '0;
        else if (diff > 34'sd255)
            v = 8'hff;
        else
            v = diff[7:0];
    end

    assign prod_r = v * tint[23:16];
    assign prod_g = v * tint[15:8];
    assign prod_b = v * tint[7:0];

    always_ff @(posedge out_stream_aclk) begin
        dx      <= req.x - cx;          // stage 1
        dy      <= req.y - cy;
        s1_sof  <= req.sof;
        s1_eol  <= req.eol;
        d2      <= dx * dx + dy * dy;   // stage 2
        s2_sof  <= s1_sof;
        s2_eol  <= s1_eol;
        res.rgb <= {prod_r[15:8], prod_g[15:8], prod_b[15:8]};   // stage 3
        res.sof <= s2_sof;
        res.eol <= s2_eol;
    end

endmodule

`default_nettype wire

/* stream_packer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module stream_packer (
    input  logic        out_stream_aclk,
    input  logic        axi_resetn,
    shade_if.sink       res [`PG_LANES],
    output logic        slot_free,
    output logic [31:0] out_stream_tdata,
    output logic        out_stream_tlast,
    output logic        out_stream_tuser,
    output logic        out_stream_tvalid,
    input  logic        out_stream_tready
);
    localparam int PW = (`PG_FIFO_DEPTH > 1) ? $clog2(`PG_FIFO_DEPTH) : 1;
    localparam int CW = $clog2(`PG_FIFO_DEPTH + 1);

    // entry layout {sof, eol, rgb}
    logic [`PG_LANES-1:0] lane_valid;
    logic [25:0]          lane_entry [`PG_LANES];
    logic [25:0]          wr_entry;
    logic [25:0]          mem [`PG_FIFO_DEPTH];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        count;
    logic                 push;
    logic                 pop;

    for (genvar i = 0; i < `PG_LANES; i++) begin : g_lane
        assign lane_valid[i] = res[i].valid;
        assign lane_entry[i] = res[i].valid ? {res[i].sof, res[i].eol, res[i].rgb} : '0;
    end

    // lanes fire in issue order, one at a time, so an OR merge is enough
    always_comb begin
        wr_entry = '0;
        for (int i = 0; i < `PG_LANES; i++)
            wr_entry = wr_entry | lane_entry[i];
    end

    assign push = |lane_valid;
    assign pop  = out_stream_tvalid && out_stream_tready;
    assign slot_free = pop;         // credit back to the scanner

    always_ff @(posedge out_stream_aclk) begin
        if (push)
            mem[wr_ptr] <= wr_entry;
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(`PG_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(`PG_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(pop);
        end
    end

    assign out_stream_tvalid = (count != '0);
    assign out_stream_tuser  = mem[rd_ptr][25];
    assign out_stream_tlast  = mem[rd_ptr][24];
    assign out_stream_tdata  = {8'h00, mem[rd_ptr][23:0]};

    // the scanner credits must keep the FIFO from overflowing
    a_no_overflow: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        push |-> count != CW'(`PG_FIFO_DEPTH));
    a_one_lane: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        $onehot0(lane_valid));

endmodule

`default_nettype wire

/* pixel_generator.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module pixel_generator (
    input  logic                          out_stream_aclk,
    input  logic                          axi_resetn,

    // stream output
    output logic [31:0]                   out_stream_tdata,
    output logic                          out_stream_tlast,
    input  logic                          out_stream_tready,
    output logic                          out_stream_tvalid,
    output logic                          out_stream_tuser,

    // AXI-Lite slave
    input  logic [`PG_AXI_ADDR_WIDTH-1:0] s_axi_lite_araddr,
    output logic                          s_axi_lite_arready,
    input  logic                          s_axi_lite_arvalid,
    input  logic [`PG_AXI_ADDR_WIDTH-1:0] s_axi_lite_awaddr,
    output logic                          s_axi_lite_awready,
    input  logic                          s_axi_lite_awvalid,
    input  logic                          s_axi_lite_bready,
    output logic [1:0]                    s_axi_lite_bresp,
    output logic                          s_axi_lite_bvalid,
    output logic [31:0]                   s_axi_lite_rdata,
    input  logic                          s_axi_lite_rready,
    output logic [1:0]                    s_axi_lite_rresp,
    output logic                          s_axi_lite_rvalid,
    input  logic [31:0]                   s_axi_lite_wdata,
    output logic                          s_axi_lite_wready,
    input  logic                          s_axi_lite_wvalid
);
    logic           run;
    logic           slot_free;
    pg_pkg::coord_t cx;
    pg_pkg::coord_t cy;
    pg_pkg::coord_t k;
    pg_pkg::rgb_t   tint;

    pixel_req_if req_if [`PG_LANES] ();
    shade_if     res_if [`PG_LANES] ();

    axi_lite_regs u_regs (
        .out_stream_aclk   (out_stream_aclk),
        .axi_resetn        (axi_resetn),
        .s_axi_lite_awaddr (s_axi_lite_awaddr),
        .s_axi_lite_awvalid(s_axi_lite_awvalid),
        .s_axi_lite_awready(s_axi_lite_awready),
        .s_axi_lite_wdata  (s_axi_lite_wdata),
        .s_axi_lite_wvalid (s_axi_lite_wvalid),
        .s_axi_lite_wready (s_axi_lite_wready),
        .s_axi_lite_bresp  (s_axi_lite_bresp),
        .s_axi_lite_bvalid (s_axi_lite_bvalid),
        .s_axi_lite_bready (s_axi_lite_bready),
        .s_axi_lite_araddr (s_axi_lite_araddr),
        .s_axi_lite_arvalid(s_axi_lite_arvalid),
        .s_axi_lite_arready(s_axi_lite_arready),
        .s_axi_lite_rdata  (s_axi_lite_rdata),
        .s_axi_lite_rresp  (s_axi_lite_rresp),
        .s_axi_lite_rvalid (s_axi_lite_rvalid),
        .s_axi_lite_rready (s_axi_lite_rready),
        .run               (run),
        .cx                (cx),
        .cy                (cy),
        .k                 (k),
        .tint              (tint)
    );

    pixel_scanner u_scanner (
        .out_stream_aclk(out_stream_aclk),
        .axi_resetn     (axi_resetn),
        .run            (run),
        .slot_free      (slot_free),
        .req            (req_if)
    );

    for (genvar i = 0; i < `PG_LANES; i++) begin : g_lane
        shade_lane u_lane (
            .out_stream_aclk(out_stream_aclk),
            .axi_resetn     (axi_resetn),
            .cx             (cx),
            .cy             (cy),
            .k              (k),
            .tint           (tint),
            .req            (req_if[i]),
            .res            (res_if[i])
        );
    end

    stream_packer u_packer (
        .out_stream_aclk  (out_stream_aclk),
        .axi_resetn       (axi_resetn),
        .res              (res_if),
        .slot_free        (slot_free),
        .out_stream_tdata (out_stream_tdata),
        .out_stream_tlast (out_stream_tlast),
        .out_stream_tuser (out_stream_tuser),
        .out_stream_tvalid(out_stream_tvalid),
        .out_stream_tready(out_stream_tready)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;   // 50 ns high, 50 ns low

endmodule

`default_nettype wire

/* tb_pixel_generator.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pg_settings.svh"

module tb_pixel_generator;
    localparam int W = `PG_WIDTH;
    localparam int H = `PG_HEIGHT;
    localparam int PIX = W * H;
    localparam int AW = `PG_AXI_ADDR_WIDTH;
    localparam int WAIT_LIMIT = 2000;   // cycles allowed in any single wait

    logic          out_stream_aclk;
    logic          axi_resetn;
    logic [31:0]   out_stream_tdata;
    logic          out_stream_tlast;
    logic          out_stream_tready = 1'b0;
    logic          out_stream_tvalid;
    logic          out_stream_tuser;
    logic [AW-1:0] s_axi_lite_araddr;
    logic          s_axi_lite_arready;
    logic          s_axi_lite_arvalid;
    logic [AW-1:0] s_axi_lite_awaddr;
    logic          s_axi_lite_awready;
    logic          s_axi_lite_awvalid;
    logic          s_axi_lite_bready;
    logic [1:0]    s_axi_lite_bresp;
    logic          s_axi_lite_bvalid;
    logic [31:0]   s_axi_lite_rdata;
    logic          s_axi_lite_rready;
    logic [1:0]    s_axi_lite_rresp;
    logic          s_axi_lite_rvalid;
    logic [31:0]   s_axi_lite_wdata;
    logic          s_axi_lite_wready;
    logic          s_axi_lite_wvalid;

    // model state
    int            m_cx;
    int            m_cy;
    int            m_k;
    logic [23:0]   m_tint;

    logic [33:0]   rx_q [$];         // {tuser, tlast, tdata} per beat
    logic          ready_pat [256];
    logic          ready_rand = 1'b0;
    int            ready_idx = 0;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            err_mark;
    logic [31:0]   vals [8];
    logic [31:0]   rd_data;
    logic [1:0]    resp;

    tb_clock_gen #(.PERIOD(100)) clock_gen_i (.clk(out_stream_aclk));

    pixel_generator pixel_generator_i (
        .out_stream_aclk   (out_stream_aclk),
        .axi_resetn        (axi_resetn),
        .out_stream_tdata  (out_stream_tdata),
        .out_stream_tlast  (out_stream_tlast),
        .out_stream_tready (out_stream_tready),
        .out_stream_tvalid (out_stream_tvalid),
        .out_stream_tuser  (out_stream_tuser),
        .s_axi_lite_araddr (s_axi_lite_araddr),
        .s_axi_lite_arready(s_axi_lite_arready),
        .s_axi_lite_arvalid(s_axi_lite_arvalid),
        .s_axi_lite_awaddr (s_axi_lite_awaddr),
        .s_axi_lite_awready(s_axi_lite_awready),
        .s_axi_lite_awvalid(s_axi_lite_awvalid),
        .s_axi_lite_bready (s_axi_lite_bready),
        .s_axi_lite_bresp  (s_axi_lite_bresp),
        .s_axi_lite_bvalid (s_axi_lite_bvalid),
        .s_axi_lite_rdata  (s_axi_lite_rdata),
        .s_axi_lite_rready (s_axi_lite_rready),
        .s_axi_lite_rresp  (s_axi_lite_rresp),
        .s_axi_lite_rvalid (s_axi_lite_rvalid),
        .s_axi_lite_wdata  (s_axi_lite_wdata),
        .s_axi_lite_wready (s_axi_lite_wready),
        .s_axi_lite_wvalid (s_axi_lite_wvalid)
    );

    // a beat counts when tvalid and the new tready meet at the next rising edge
    always @(negedge out_stream_aclk) begin
        ready_idx = (ready_idx + 1) % 256;
        out_stream_tready = ready_rand ? ready_pat[ready_idx] : 1'b1;
        if (axi_resetn && out_stream_tvalid && out_stream_tready)
            rx_q.push_back({out_stream_tuser, out_stream_tlast, out_stream_tdata});
    end

    // radial falloff then tint
    function automatic logic [31:0] expected_pixel(input int x, input int y);
        int dx;
        int dy;
        int d2;
        int v;
        int r;
        int g;
        int b;
        dx = x - m_cx;
        dy = y - m_cy;
        d2 = dx * dx + dy * dy;
        v = m_k - (d2 >> `PG_SHIFT);
        if (v < 0)
            v = 0;
        else if (v > 255)
            v = 255;
        r = (v * int'(m_tint[23:16])) >> 8;
        g = (v * int'(m_tint[15:8])) >> 8;
        b = (v * int'(m_tint[7:0])) >> 8;
        return {8'h00, 8'(r), 8'(g), 8'(b)};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $finish;
    endtask

    // order 0 sends both together while 1 leads with the address and 2 with the data
    task automatic write_reg(input int idx, input logic [31:0] data, input int order,
                             output logic [1:0] wr_resp);
        bit aw_hit;
        bit w_hit;
        bit aw_done;
        bit w_done;
        int t;
        aw_done = 1'b0;
        w_done = 1'b0;
        t = 0;
        @(negedge out_stream_aclk);
        s_axi_lite_awaddr = AW'(idx * 4);
        s_axi_lite_wdata = data;
        s_axi_lite_awvalid = (order != 2);
        s_axi_lite_wvalid = (order != 1);
        while (!(aw_done && w_done)) begin
            aw_hit = s_axi_lite_awvalid && s_axi_lite_awready;
            w_hit = s_axi_lite_wvalid && s_axi_lite_wready;
            @(negedge out_stream_aclk);
            if (aw_hit) begin
                s_axi_lite_awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit) begin
                s_axi_lite_wvalid = 1'b0;
                w_done = 1'b1;
            end
            if (!aw_done && !s_axi_lite_awvalid)
                s_axi_lite_awvalid = 1'b1;   // second half of a split write
            if (!w_done && !s_axi_lite_wvalid)
                s_axi_lite_wvalid = 1'b1;
            t++;
            if (t > WAIT_LIMIT)
                abort_run("timeout waiting for awready or wready");
        end
        s_axi_lite_bready = 1'b1;
        t = 0;
        while (!s_axi_lite_bvalid) begin
            @(negedge out_stream_aclk);
            t++;
            if (t > WAIT_LIMIT)
                abort_run("timeout waiting for bvalid");
        end
        wr_resp = s_axi_lite_bresp;
        @(negedge out_stream_aclk);
        s_axi_lite_bready = 1'b0;
    endtask

    task automatic read_reg(input int idx, output logic [31:0] data,
                            output logic [1:0] rd_resp);
        int t;
        t = 0;
        @(negedge out_stream_aclk);
        s_axi_lite_araddr = AW'(idx * 4);
        s_axi_lite_arvalid = 1'b1;
        while (!s_axi_lite_arready) begin
            @(negedge out_stream_aclk);
            t++;
            if (t > WAIT_LIMIT)
                abort_run("timeout waiting for arready");
        end
        @(negedge out_stream_aclk);
        s_axi_lite_arvalid = 1'b0;
        s_axi_lite_rready = 1'b1;
        t = 0;
        while (!s_axi_lite_rvalid) begin
            @(negedge out_stream_aclk);
            t++;
            if (t > WAIT_LIMIT)
                abort_run("timeout waiting for rvalid");
        end
        data = s_axi_lite_rdata;
        rd_resp = s_axi_lite_rresp;
        @(negedge out_stream_aclk);
        s_axi_lite_rready = 1'b0;
    endtask

    task automatic set_run(input logic on);
        logic [1:0] r;
        write_reg(0, {31'd0, on}, 0, r);
        if (r != 2'b00) begin
            $display("FAILED at %0t: run write got bresp %b", $time, r);
            errors++;
        end
    endtask

    // run is only sampled at frame start so a quick set and clear gives one frame
    task automatic start_frame();
        set_run(1'b1);
        set_run(1'b0);
    endtask

    task automatic wait_beats(input int n);
        int t;
        t = 0;
        while (rx_q.size() < n) begin
            @(negedge out_stream_aclk);
            t++;
            if (t > WAIT_LIMIT)
                abort_run($sformatf("timeout, only %0d of %0d beats arrived", rx_q.size(), n));
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge out_stream_aclk);
            if (out_stream_tvalid) begin
                $display("FAILED at %0t: tvalid seen after the last frame ended", $time);
                errors++;
                return;
            end
        end
    endtask

    task automatic check_values();
        logic [31:0] exp;
        for (int i = 0; i < rx_q.size(); i++) begin
            exp = expected_pixel(i % W, (i / W) % H);
            if (rx_q[i][31:0] != exp) begin
                $display("FAILED at %0t: beat %0d tdata %h, expected %h",
                         $time, i, rx_q[i][31:0], exp);
                errors++;
            end
        end
    endtask

    task automatic check_framing(input int frames);
        if (rx_q.size() != frames * PIX) begin
            $display("FAILED at %0t: %0d beats, expected %0d", $time, rx_q.size(), frames * PIX);
            errors++;
        end
        for (int i = 0; i < rx_q.size(); i++) begin
            if (rx_q[i][33] != (i % PIX == 0)) begin
                $display("FAILED at %0t: beat %0d tuser %b", $time, i, rx_q[i][33]);
                errors++;
            end
            if (rx_q[i][32] != (i % W == W - 1)) begin
                $display("FAILED at %0t: beat %0d tlast %b", $time, i, rx_q[i][32]);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        axi_resetn = 1'b0;
        s_axi_lite_araddr = '0;
        s_axi_lite_arvalid = 1'b0;
        s_axi_lite_awaddr = '0;
        s_axi_lite_awvalid = 1'b0;
        s_axi_lite_bready = 1'b0;
        s_axi_lite_rready = 1'b0;
        s_axi_lite_wdata = '0;
        s_axi_lite_wvalid = 1'b0;
        void'($urandom(32'h9ff));
        repeat (16) @(negedge out_stream_aclk);
        axi_resetn = 1'b1;

        // registers get random values in random channel order
        err_mark = errors;
        for (int i = 0; i < 8; i++) begin
            vals[i] = $urandom;
            if (i == 0)
                vals[i][0] = 1'b0;   // keep the scanner idle
            write_reg(i, vals[i], $urandom_range(0, 2), resp);
            if (resp != 2'b00) begin
                $display("FAILED at %0t: reg %0d bresp %b", $time, i, resp);
                errors++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            read_reg(i, rd_data, resp);
            if (rd_data != vals[i] || resp != 2'b00) begin
                $display("FAILED at %0t: reg %0d read %h resp %b, expected %h",
                         $time, i, rd_data, resp, vals[i]);
                errors++;
            end
        end
        write_reg(9, $urandom, 0, resp);
        if (resp != 2'b10) begin
            $display("FAILED at %0t: write to word 9 bresp %b, expected SLVERR", $time, resp);
            errors++;
        end
        read_reg(9, rd_data, resp);
        if (resp != 2'b10) begin
            $display("FAILED at %0t: read of word 9 rresp %b, expected SLVERR", $time, resp);
            errors++;
        end
        end_test("registers", err_mark);

        // pixel values over one frame at full speed
        err_mark = errors;
        m_cx = $urandom_range(0, 2 * W - 1);
        m_cy = $urandom_range(0, 2 * H - 1);
        m_k = $urandom_range(32, 400);       // clamps at both ends
        m_tint = 24'($urandom);
        write_reg(1, 32'(m_cx), $urandom_range(0, 2), resp);
        write_reg(2, 32'(m_cy), $urandom_range(0, 2), resp);
        write_reg(3, 32'(m_k), $urandom_range(0, 2), resp);
        write_reg(4, {8'h00, m_tint}, $urandom_range(0, 2), resp);
        rx_q.delete();
        start_frame();
        wait_beats(PIX);
        check_values();
        end_test("pixel values", err_mark);

        // framing over two back to back frames
        err_mark = errors;
        rx_q.delete();
        set_run(1'b1);
        wait_beats(PIX + 4);
        set_run(1'b0);
        wait_beats(2 * PIX);
        expect_quiet(300);
        check_framing(2);
        check_values();
        end_test("framing", err_mark);

        // back-pressure with random tready
        err_mark = errors;
        foreach (ready_pat[i])
            ready_pat[i] = 1'($urandom_range(0, 1));
        rx_q.delete();
        ready_rand = 1'b1;
        start_frame();
        wait_beats(PIX);
        expect_quiet(300);
        ready_rand = 1'b0;
        check_framing(1);
        check_values();
        end_test("back-pressure", err_mark);

        // stop in the middle of a frame
        err_mark = errors;
        rx_q.delete();
        set_run(1'b1);
        wait_beats(PIX / 2);
        set_run(1'b0);
        wait_beats(PIX);
        expect_quiet(300);
        check_framing(1);
        end_test("stop", err_mark);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
pg_pkg.sv
pg_if.sv
axi_lite_regs.sv
pixel_scanner.sv
shade_lane.sv
stream_packer.sv
pixel_generator.sv
tb_clock_gen.sv
tb_pixel_generator.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pixel_generator
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
